//--- include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and pc width
`define XLEN 32
`define NUM_REGS 32
`define REG_ADDR_W 5

// instruction field positions
`define OPCODE_MSB 6
`define OPCODE_LSB 0
`define RD_MSB 11
`define RD_LSB 7
`define FUNCT3_MSB 14
`define FUNCT3_LSB 12
`define RS1_MSB 19
`define RS1_LSB 15
`define RS2_MSB 24
`define RS2_LSB 20
// funct7 bit that selects SUB and SRA
`define INSTR_ALT_BIT 30

`endif

//--- hdl/rv_pkg.sv
package rv_pkg;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// zero encodings are the bubble defaults
	typedef enum logic [4:0] {
		ALU_ADD    = 5'd0,
		ALU_SUB    = 5'd1,
		ALU_SLL    = 5'd2,
		ALU_SLT    = 5'd3,
		ALU_SLTU   = 5'd4,
		ALU_XOR    = 5'd5,
		ALU_SRL    = 5'd6,
		ALU_SRA    = 5'd7,
		ALU_OR     = 5'd8,
		ALU_AND    = 5'd9,
		ALU_PASS_B = 5'd10
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
	} br_sel_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_PC4, WB_MEM
	} wb_sel_e;

endpackage

//--- hdl/id_ex_if.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

interface id_ex_if
	import rv_pkg::*;
();
	logic [`XLEN-1:0]       pc;
	logic [`REG_ADDR_W-1:0] rs1_addr;
	logic [`REG_ADDR_W-1:0] rs2_addr;
	logic [`REG_ADDR_W-1:0] rd_addr;
	logic [`XLEN-1:0]       rs1_data;
	logic [`XLEN-1:0]       rs2_data;
	logic [`XLEN-1:0]       imm;
	br_sel_e                br_sel;
	logic                   jump;
	logic                   jalr;
	logic                   rd_wren;
	logic                   mem_wren;
	logic                   insn_vld;
	// opa_sel picks pc over rs1, opb_sel picks imm over rs2
	logic                   opa_sel;
	logic                   opb_sel;
	alu_op_e                alu_op;
	wb_sel_e                wb_sel;

	modport dec_src (output pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm, br_sel,
		jump, jalr, rd_wren, mem_wren, insn_vld, opa_sel, opb_sel, alu_op, wb_sel);
	modport reg_in (input pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm, br_sel,
		jump, jalr, rd_wren, mem_wren, insn_vld, opa_sel, opb_sel, alu_op, wb_sel);
	modport reg_out (output pc, rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm, br_sel,
		jump, jalr, rd_wren, mem_wren, insn_vld, opa_sel, opb_sel, alu_op, wb_sel);
	modport ex_sink (input pc, rd_addr, rs1_data, rs2_data, imm, br_sel,
		jump, jalr, rd_wren, mem_wren, insn_vld, opa_sel, opb_sel, alu_op, wb_sel);

endinterface

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module reg_file (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic [`REG_ADDR_W-1:0] i_rs1_addr,
	input  logic [`REG_ADDR_W-1:0] i_rs2_addr,
	input  logic                   i_wr_en,
	input  logic [`REG_ADDR_W-1:0] i_wr_addr,
	input  logic [`XLEN-1:0]       i_wr_data,
	output logic [`XLEN-1:0]       o_rs1_data,
	output logic [`XLEN-1:0]       o_rs2_data
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (~i_reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && (i_wr_addr != '0)) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// x0 always reads as zero
	assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
	assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module instr_decoder
	import rv_pkg::*;
(
	input  logic                   i_instr_valid,
	input  logic [`XLEN-1:0]       i_instr,
	input  logic [`XLEN-1:0]       i_pc,
	input  logic                   i_stall,
	output logic                   o_instr_ready,
	output logic [`REG_ADDR_W-1:0] o_rs1_addr,
	output logic [`REG_ADDR_W-1:0] o_rs2_addr,
	input  logic [`XLEN-1:0]       i_rs1_data,
	input  logic [`XLEN-1:0]       i_rs2_data,
	id_ex_if.dec_src               o_bus
);

	opcode_e          opcode;
	logic [2:0]       funct3;
	logic             alt;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [`XLEN-1:0] imm;
	logic             known;
	logic             vld;
	alu_op_e          alu_op;
	br_sel_e          br_sel;
	wb_sel_e          wb_sel;
	logic             jump;
	logic             jalr;
	logic             rd_wren;
	logic             mem_wren;
	logic             opa_sel;
	logic             opb_sel;

	// sub only exists for register operands, sra for both
	function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic f7_alt,
			input logic is_reg);
		case (f3)
			3'b000: return (f7_alt && is_reg) ? ALU_SUB : ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b011: return ALU_SLTU;
			3'b100: return ALU_XOR;
			3'b101: return f7_alt ? ALU_SRA : ALU_SRL;
			3'b110: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_e'(i_instr[`OPCODE_MSB:`OPCODE_LSB]);
	assign funct3 = i_instr[`FUNCT3_MSB:`FUNCT3_LSB];
	assign alt    = i_instr[`INSTR_ALT_BIT];

	assign imm_i = {{(`XLEN-12){i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{(`XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_b = {{(`XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
		i_instr[11:8], 1'b0};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{(`XLEN-21){i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
		i_instr[30:21], 1'b0};

	always_comb begin
		known    = 1'b1;
		alu_op   = ALU_ADD;
		br_sel   = BR_NONE;
		wb_sel   = WB_ALU;
		jump     = 1'b0;
		jalr     = 1'b0;
		rd_wren  = 1'b0;
		mem_wren = 1'b0;
		opa_sel  = 1'b0;
		opb_sel  = 1'b1;
		imm      = imm_i;
		case (opcode)
			OPC_LUI: begin
				alu_op  = ALU_PASS_B;
				imm     = imm_u;
				rd_wren = 1'b1;
			end
			OPC_AUIPC: begin
				opa_sel = 1'b1;
				imm     = imm_u;
				rd_wren = 1'b1;
			end
			OPC_JAL: begin
				jump    = 1'b1;
				imm     = imm_j;
				wb_sel  = WB_PC4;
				rd_wren = 1'b1;
			end
			OPC_JALR: begin
				jump    = 1'b1;
				jalr    = 1'b1;
				wb_sel  = WB_PC4;
				rd_wren = 1'b1;
			end
			OPC_BRANCH: begin
				imm = imm_b;
				case (funct3)
					3'b000: br_sel = BR_EQ;
					3'b001: br_sel = BR_NE;
					3'b100: br_sel = BR_LT;
					3'b101: br_sel = BR_GE;
					3'b110: br_sel = BR_LTU;
					3'b111: br_sel = BR_GEU;
					default: known = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				wb_sel  = WB_MEM;
				rd_wren = 1'b1;
			end
			OPC_STORE: begin
				imm      = imm_s;
				mem_wren = 1'b1;
			end
			OPC_OP_IMM: begin
				alu_op  = alu_from_funct(funct3, alt, 1'b0);
				rd_wren = 1'b1;
			end
			OPC_OP: begin
				opb_sel = 1'b0;
				alu_op  = alu_from_funct(funct3, alt, 1'b1);
				rd_wren = 1'b1;
			end
			default: known = 1'b0;
		endcase
	end

	// an unknown opcode still takes the transfer but leaves a bubble
	assign vld           = i_instr_valid & ~i_stall & known;
	assign o_instr_ready = ~i_stall;
	assign o_rs1_addr    = i_instr[`RS1_MSB:`RS1_LSB];
	assign o_rs2_addr    = i_instr[`RS2_MSB:`RS2_LSB];

	assign o_bus.pc       = i_pc;
	assign o_bus.rs1_addr = o_rs1_addr;
	assign o_bus.rs2_addr = o_rs2_addr;
	assign o_bus.rd_addr  = i_instr[`RD_MSB:`RD_LSB];
	assign o_bus.rs1_data = i_rs1_data;
	assign o_bus.rs2_data = i_rs2_data;
	assign o_bus.imm      = imm;
	assign o_bus.br_sel   = br_sel;
	assign o_bus.jump     = jump;
	assign o_bus.jalr     = jalr;
	assign o_bus.rd_wren  = rd_wren & vld;
	assign o_bus.mem_wren = mem_wren & vld;
	assign o_bus.insn_vld = vld;
	assign o_bus.opa_sel  = opa_sel;
	assign o_bus.opb_sel  = opb_sel;
	assign o_bus.alu_op   = alu_op;
	assign o_bus.wb_sel   = wb_sel;

endmodule

//--- hdl/flip_flop_decode_execute.sv
`timescale 1ns/1ps

module flip_flop_decode_execute
	import rv_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_flush_execute,
	input  logic       i_stall_execute,
	id_ex_if.reg_in    i_dec,
	id_ex_if.reg_out   o_ex
);

	always_ff @(posedge i_clk or negedge i_reset) begin
		if (~i_reset) begin
			o_ex.pc       <= '0;
			o_ex.rs1_addr <= '0;
			o_ex.rs2_addr <= '0;
			o_ex.rd_addr  <= '0;
			o_ex.rs1_data <= '0;
			o_ex.rs2_data <= '0;
			o_ex.imm      <= '0;
			o_ex.br_sel   <= BR_NONE;
			o_ex.jump     <= 1'b0;
			o_ex.jalr     <= 1'b0;
			o_ex.rd_wren  <= 1'b0;
			o_ex.mem_wren <= 1'b0;
			o_ex.insn_vld <= 1'b0;
			o_ex.opa_sel  <= 1'b0;
			o_ex.opb_sel  <= 1'b0;
			o_ex.alu_op   <= ALU_ADD;
			o_ex.wb_sel   <= WB_ALU;
		end else if (i_flush_execute) begin
			// the instruction behind a taken branch becomes a bubble
			o_ex.pc       <= '0;
			o_ex.rs1_addr <= '0;
			o_ex.rs2_addr <= '0;
			o_ex.rd_addr  <= '0;
			o_ex.rs1_data <= '0;
			o_ex.rs2_data <= '0;
			o_ex.imm      <= '0;
			o_ex.br_sel   <= BR_NONE;
			o_ex.jump     <= 1'b0;
			o_ex.jalr     <= 1'b0;
			o_ex.rd_wren  <= 1'b0;
			o_ex.mem_wren <= 1'b0;
			o_ex.insn_vld <= 1'b0;
			o_ex.opa_sel  <= 1'b0;
			o_ex.opb_sel  <= 1'b0;
			o_ex.alu_op   <= ALU_ADD;
			o_ex.wb_sel   <= WB_ALU;
		end else if (~i_stall_execute) begin
			o_ex.pc       <= i_dec.pc;
			o_ex.rs1_addr <= i_dec.rs1_addr;
			o_ex.rs2_addr <= i_dec.rs2_addr;
			o_ex.rd_addr  <= i_dec.rd_addr;
			o_ex.rs1_data <= i_dec.rs1_data;
			o_ex.rs2_data <= i_dec.rs2_data;
			o_ex.imm      <= i_dec.imm;
			o_ex.br_sel   <= i_dec.br_sel;
			o_ex.jump     <= i_dec.jump;
			o_ex.jalr     <= i_dec.jalr;
			o_ex.rd_wren  <= i_dec.rd_wren;
			o_ex.mem_wren <= i_dec.mem_wren;
			o_ex.insn_vld <= i_dec.insn_vld;
			o_ex.opa_sel  <= i_dec.opa_sel;
			o_ex.opb_sel  <= i_dec.opb_sel;
			o_ex.alu_op   <= i_dec.alu_op;
			o_ex.wb_sel   <= i_dec.wb_sel;
		end
	end

endmodule

//--- hdl/execute_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module execute_unit
	import rv_pkg::*;
(
	id_ex_if.ex_sink               i_bus,
	input  logic                   i_res_ready,
	output logic                   o_res_valid,
	output logic [`XLEN-1:0]       o_res_pc,
	output logic [`REG_ADDR_W-1:0] o_res_rd_addr,
	output logic                   o_res_rd_wren,
	output logic                   o_res_mem_wren,
	output logic [`XLEN-1:0]       o_res_value,
	output logic [`XLEN-1:0]       o_res_store_data,
	output logic                   o_res_br_taken,
	output logic [`XLEN-1:0]       o_res_br_target,
	output logic                   o_stall,
	output logic                   o_flush
);

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_res;
	logic [4:0]       shamt;
	logic             cond;
	logic [`XLEN-1:0] jalr_sum;

	assign op_a  = i_bus.opa_sel ? i_bus.pc : i_bus.rs1_data;
	assign op_b  = i_bus.opb_sel ? i_bus.imm : i_bus.rs2_data;
	assign shamt = op_b[4:0];

	always_comb begin
		case (i_bus.alu_op)
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_SLL:    alu_res = op_a << shamt;
			ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLTU:   alu_res = {{(`XLEN-1){1'b0}}, op_a < op_b};
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SRL:    alu_res = op_a >> shamt;
			ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
			ALU_OR:     alu_res = op_a | op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_PASS_B: alu_res = op_b;
			default:    alu_res = op_a + op_b;
		endcase
	end

	// branch conditions always compare the two register operands
	always_comb begin
		case (i_bus.br_sel)
			BR_EQ:   cond = i_bus.rs1_data == i_bus.rs2_data;
			BR_NE:   cond = i_bus.rs1_data != i_bus.rs2_data;
			BR_LT:   cond = $signed(i_bus.rs1_data) < $signed(i_bus.rs2_data);
			BR_GE:   cond = $signed(i_bus.rs1_data) >= $signed(i_bus.rs2_data);
			BR_LTU:  cond = i_bus.rs1_data < i_bus.rs2_data;
			BR_GEU:  cond = i_bus.rs1_data >= i_bus.rs2_data;
			default: cond = 1'b0;
		endcase
	end

	assign jalr_sum        = i_bus.rs1_data + i_bus.imm;
	assign o_res_br_target = i_bus.jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : i_bus.pc + i_bus.imm;
	assign o_res_br_taken  = i_bus.insn_vld & (i_bus.jump | cond);

	assign o_res_valid      = i_bus.insn_vld;
	assign o_res_pc         = i_bus.pc;
	assign o_res_rd_addr    = i_bus.rd_addr;
	assign o_res_rd_wren    = i_bus.rd_wren;
	assign o_res_mem_wren   = i_bus.mem_wren;
	assign o_res_value      = (i_bus.wb_sel == WB_PC4) ? i_bus.pc + 32'd4 : alu_res;
	assign o_res_store_data = i_bus.rs2_data;

	assign o_stall = i_bus.insn_vld & ~i_res_ready;
	// flush fires only on the edge where the taken result is accepted
	assign o_flush = i_bus.insn_vld & i_res_ready & o_res_br_taken;

endmodule

//--- hdl/rv_decode_execute_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode_execute_top (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_instr_valid,
	input  logic [`XLEN-1:0]       i_instr,
	input  logic [`XLEN-1:0]       i_pc,
	output logic                   o_instr_ready,
	input  logic                   i_res_ready,
	output logic                   o_res_valid,
	output logic [`XLEN-1:0]       o_res_pc,
	output logic [`REG_ADDR_W-1:0] o_res_rd_addr,
	output logic                   o_res_rd_wren,
	output logic                   o_res_mem_wren,
	output logic [`XLEN-1:0]       o_res_value,
	output logic [`XLEN-1:0]       o_res_store_data,
	output logic                   o_res_br_taken,
	output logic [`XLEN-1:0]       o_res_br_target,
	input  logic                   i_wb_wren,
	input  logic [`REG_ADDR_W-1:0] i_wb_addr,
	input  logic [`XLEN-1:0]       i_wb_data
);

	logic [`REG_ADDR_W-1:0] rs1_addr;
	logic [`REG_ADDR_W-1:0] rs2_addr;
	logic [`XLEN-1:0]       rs1_data;
	logic [`XLEN-1:0]       rs2_data;
	logic                   stall;
	logic                   flush;

	id_ex_if dec_bus ();
	id_ex_if ex_bus ();

	reg_file u_reg_file (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_rs1_addr (rs1_addr),
		.i_rs2_addr (rs2_addr),
		.i_wr_en    (i_wb_wren),
		.i_wr_addr  (i_wb_addr),
		.i_wr_data  (i_wb_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	instr_decoder u_decoder (
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_pc          (i_pc),
		.i_stall       (stall),
		.o_instr_ready (o_instr_ready),
		.o_rs1_addr    (rs1_addr),
		.o_rs2_addr    (rs2_addr),
		.i_rs1_data    (rs1_data),
		.i_rs2_data    (rs2_data),
		.o_bus         (dec_bus)
	);

	flip_flop_decode_execute u_id_ex (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_flush_execute (flush),
		.i_stall_execute (stall),
		.i_dec           (dec_bus),
		.o_ex            (ex_bus)
	);

	execute_unit u_execute (
		.i_bus            (ex_bus),
		.i_res_ready      (i_res_ready),
		.o_res_valid      (o_res_valid),
		.o_res_pc         (o_res_pc),
		.o_res_rd_addr    (o_res_rd_addr),
		.o_res_rd_wren    (o_res_rd_wren),
		.o_res_mem_wren   (o_res_mem_wren),
		.o_res_value      (o_res_value),
		.o_res_store_data (o_res_store_data),
		.o_res_br_taken   (o_res_br_taken),
		.o_res_br_target  (o_res_br_target),
		.o_stall          (stall),
		.o_flush          (flush)
	);

endmodule

//--- bench/tb_rv_decode_execute.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_decode_execute;

	localparam int REC_WORDS = 10;
	localparam int MAX_RECS = 64;
	localparam int IDLE_LIMIT = 40;

	logic                   i_clk;
	logic                   i_reset;
	logic                   i_instr_valid;
	logic [`XLEN-1:0]       i_instr;
	logic [`XLEN-1:0]       i_pc;
	logic                   o_instr_ready;
	logic                   i_res_ready;
	logic                   o_res_valid;
	logic [`XLEN-1:0]       o_res_pc;
	logic [`REG_ADDR_W-1:0] o_res_rd_addr;
	logic                   o_res_rd_wren;
	logic                   o_res_mem_wren;
	logic [`XLEN-1:0]       o_res_value;
	logic [`XLEN-1:0]       o_res_store_data;
	logic                   o_res_br_taken;
	logic [`XLEN-1:0]       o_res_br_target;
	logic                   i_wb_wren;
	logic [`REG_ADDR_W-1:0] i_wb_addr;
	logic [`XLEN-1:0]       i_wb_data;

	// each record holds kind, pc or reg, instr or value, rd, wren, mem_wren, value,
	// store data, taken and target
	logic [31:0]            golden [REC_WORDS*MAX_RECS];
	int                     preload_recs[$];
	int                     instr_recs[$];
	int                     exp_q[$];

	logic                   held;
	logic [`XLEN-1:0]       held_pc;
	logic [`REG_ADDR_W-1:0] held_rd;
	logic                   held_rd_wren;
	logic                   held_mem_wren;
	logic [`XLEN-1:0]       held_value;
	logic [`XLEN-1:0]       held_store;
	logic                   held_taken;
	logic [`XLEN-1:0]       held_target;

	rv_decode_execute_top i_dut (
		.i_clk            (i_clk),
		.i_reset          (i_reset),
		.i_instr_valid    (i_instr_valid),
		.i_instr          (i_instr),
		.i_pc             (i_pc),
		.o_instr_ready    (o_instr_ready),
		.i_res_ready      (i_res_ready),
		.o_res_valid      (o_res_valid),
		.o_res_pc         (o_res_pc),
		.o_res_rd_addr    (o_res_rd_addr),
		.o_res_rd_wren    (o_res_rd_wren),
		.o_res_mem_wren   (o_res_mem_wren),
		.o_res_value      (o_res_value),
		.o_res_store_data (o_res_store_data),
		.o_res_br_taken   (o_res_br_taken),
		.o_res_br_target  (o_res_br_target),
		.i_wb_wren        (i_wb_wren),
		.i_wb_addr        (i_wb_addr),
		.i_wb_data        (i_wb_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
			input logic [`XLEN-1:0] got);
		if (got !== exp) begin
			abort_run($sformatf("Fail %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_reg(input string name, input logic [`REG_ADDR_W-1:0] exp,
			input logic [`REG_ADDR_W-1:0] got);
		if (got !== exp) begin
			abort_run($sformatf("Fail %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			abort_run($sformatf("Fail %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic load_golden();
		int r;
		for (int i = 0; i < REC_WORDS*MAX_RECS; i++) begin
			golden[i] = 32'hffff_0000 | 32'(i);
		end
		$readmemh("bench/rv_golden.txt", golden);
		r = 0;
		while (r < MAX_RECS && golden[r*REC_WORDS] <= 32'd2) begin
			if (golden[r*REC_WORDS] == 32'd0) begin
				preload_recs.push_back(r);
			end else begin
				instr_recs.push_back(r);
			end
			r++;
		end
		if (instr_recs.size() == 0) begin
			abort_run("the golden file holds no instructions");
		end
	endtask

	task automatic apply_preloads();
		int b;
		foreach (preload_recs[k]) begin
			b = preload_recs[k] * REC_WORDS;
			@(negedge i_clk);
			i_wb_wren = 1'b1;
			i_wb_addr = golden[b+1][`REG_ADDR_W-1:0];
			i_wb_data = golden[b+2];
			check_bit("o_res_valid", 1'b0, o_res_valid);
		end
		@(negedge i_clk);
		i_wb_wren = 1'b0;
	endtask

	// fields that do not apply to the instruction kind are left unchecked
	task automatic check_result(input int rec);
		int b;
		b = rec * REC_WORDS;
		check_word("o_res_pc", golden[b+1], o_res_pc);
		check_bit("o_res_rd_wren", golden[b+4][0], o_res_rd_wren);
		check_bit("o_res_mem_wren", golden[b+5][0], o_res_mem_wren);
		check_bit("o_res_br_taken", golden[b+8][0], o_res_br_taken);
		if (golden[b+4][0]) begin
			check_reg("o_res_rd_addr", golden[b+3][`REG_ADDR_W-1:0], o_res_rd_addr);
		end
		if (golden[b+4][0] || golden[b+5][0]) begin
			check_word("o_res_value", golden[b+6], o_res_value);
		end
		if (golden[b+5][0]) begin
			check_word("o_res_store_data", golden[b+7], o_res_store_data);
		end
		if (golden[b+8][0]) begin
			check_word("o_res_br_target", golden[b+9], o_res_br_target);
		end
	endtask

	task automatic snapshot_held();
		held_pc       = o_res_pc;
		held_rd       = o_res_rd_addr;
		held_rd_wren  = o_res_rd_wren;
		held_mem_wren = o_res_mem_wren;
		held_value    = o_res_value;
		held_store    = o_res_store_data;
		held_taken    = o_res_br_taken;
		held_target   = o_res_br_target;
	endtask

	task automatic check_held();
		check_bit("o_res_valid", 1'b1, o_res_valid);
		check_word("o_res_pc", held_pc, o_res_pc);
		check_reg("o_res_rd_addr", held_rd, o_res_rd_addr);
		check_bit("o_res_rd_wren", held_rd_wren, o_res_rd_wren);
		check_bit("o_res_mem_wren", held_mem_wren, o_res_mem_wren);
		check_word("o_res_value", held_value, o_res_value);
		check_word("o_res_store_data", held_store, o_res_store_data);
		check_bit("o_res_br_taken", held_taken, o_res_br_taken);
		check_word("o_res_br_target", held_target, o_res_br_target);
	endtask

	// inputs change on the falling edge and outputs are sampled 1 ns later
	task automatic run_stream();
		int b;
		int issue_idx;
		int idle;
		logic exp_valid;
		issue_idx = 0;
		idle = 0;
		held = 1'b0;
		b = 0;
		while (issue_idx < instr_recs.size() || exp_q.size() > 0) begin
			@(negedge i_clk);
			i_res_ready = ($urandom % 4) != 0;
			if (issue_idx < instr_recs.size()) begin
				b = instr_recs[issue_idx] * REC_WORDS;
				i_instr_valid = 1'b1;
				i_pc = golden[b+1];
				i_instr = golden[b+2];
			end else begin
				i_instr_valid = 1'b0;
			end
			#1;
			// an owed result sits in execute until it is taken
			exp_valid = exp_q.size() != 0;
			check_bit("o_res_valid", exp_valid, o_res_valid);
			if (held) begin
				check_held();
			end
			check_bit("o_instr_ready", !(exp_valid && !i_res_ready), o_instr_ready);
			held = 1'b0;
			idle++;
			if (o_res_valid && i_res_ready) begin
				check_result(exp_q.pop_front());
				idle = 0;
			end else if (o_res_valid) begin
				snapshot_held();
				held = 1'b1;
			end
			if (i_instr_valid && o_instr_ready) begin
				if (golden[b] == 32'd1) begin
					exp_q.push_back(instr_recs[issue_idx]);
				end
				issue_idx++;
				idle = 0;
			end
			if (idle > IDLE_LIMIT) begin
				abort_run("timed out waiting for the DUT to accept or return an instruction");
			end
		end
	endtask

	initial begin
		void'($urandom(32'hcb90));
		i_reset       = 1'b0;
		i_instr_valid = 1'b0;
		i_instr       = '0;
		i_pc          = '0;
		i_res_ready   = 1'b0;
		i_wb_wren     = 1'b0;
		i_wb_addr     = '0;
		i_wb_data     = '0;
		repeat (5) @(negedge i_clk);
		i_reset = 1'b1;
		load_golden();
		check_bit("o_res_valid", 1'b0, o_res_valid);
		check_bit("o_res_br_taken", 1'b0, o_res_br_taken);
		check_bit("o_res_rd_wren", 1'b0, o_res_rd_wren);
		check_bit("o_res_mem_wren", 1'b0, o_res_mem_wren);
		apply_preloads();
		run_stream();
		// nothing may come out once the stream has drained
		repeat (4) begin
			@(negedge i_clk);
			i_instr_valid = 1'b0;
			i_res_ready = 1'b1;
			#1;
			check_bit("o_res_valid", 1'b0, o_res_valid);
		end
		$display("test passed");
		$finish;
	end

endmodule

//--- rv_slice.f
+incdir+include
hdl/rv_pkg.sv
hdl/id_ex_if.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/flip_flop_decode_execute.sv
hdl/execute_unit.sv
hdl/rv_decode_execute_top.sv
bench/tb_rv_decode_execute.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_rv_decode_execute -f rv_slice.f -o tb_sim || exit 1
sim_out=$(./obj_dir/tb_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "test passed" && exit 0 || exit 1

//--- bench/rv_golden.txt
// kind(0 preload, 1 result, 2 no result) pc|reg instr|value rd rd_wren mem_wren
// value store_data taken target; preload rows use pc as reg and instr as value
0 00000000 deadbeef 0 0 0 00000000 00000000 0 00000000
0 00000001 00000005 0 0 0 00000000 00000000 0 00000000
0 00000002 00000003 0 0 0 00000000 00000000 0 00000000
0 00000003 fffffff0 0 0 0 00000000 00000000 0 00000000
0 00000004 00000100 0 0 0 00000000 00000000 0 00000000
1 00000000 00208533 0a 1 0 00000008 00000000 0 00000000
1 00000004 402085b3 0b 1 0 00000002 00000000 0 00000000
1 00000008 00209633 0c 1 0 00000028 00000000 0 00000000
1 0000000c 0011a6b3 0d 1 0 00000001 00000000 0 00000000
1 00000010 0011b733 0e 1 0 00000000 00000000 0 00000000
1 00000014 0020c7b3 0f 1 0 00000006 00000000 0 00000000
1 00000018 0021d833 10 1 0 1ffffffe 00000000 0 00000000
1 0000001c 4021d8b3 11 1 0 fffffffe 00000000 0 00000000
1 00000020 0020e933 12 1 0 00000007 00000000 0 00000000
1 00000024 0020f9b3 13 1 0 00000001 00000000 0 00000000
1 00000028 fff08a13 14 1 0 00000004 00000000 0 00000000
1 0000002c 4041da93 15 1 0 ffffffff 00000000 0 00000000
1 00000030 0011ab13 16 1 0 00000001 00000000 0 00000000
1 00000034 00200bb3 17 1 0 00000003 00000000 0 00000000
1 00000038 12345c37 18 1 0 12345000 00000000 0 00000000
1 0000003c 00001c97 19 1 0 0000103c 00000000 0 00000000
1 00000040 00222423 08 0 1 00000108 00000003 0 00000000
1 00000044 fe122e23 1c 0 1 000000fc 00000005 0 00000000
2 00000048 30001073 0 0 0 00000000 00000000 0 00000000
1 0000004c 00108863 0 0 0 00000000 00000000 1 0000005c
2 00000050 00208533 0 0 0 00000000 00000000 0 00000000
1 00000054 00109863 0 0 0 00000000 00000000 0 00000000
1 00000058 fe209ce3 0 0 0 00000000 00000000 1 00000050
2 0000005c 00208533 0 0 0 00000000 00000000 0 00000000
1 00000060 0011c863 0 0 0 00000000 00000000 1 00000070
2 00000064 00208533 0 0 0 00000000 00000000 0 00000000
1 00000068 0011e863 0 0 0 00000000 00000000 0 00000000
1 0000006c 0011d863 0 0 0 00000000 00000000 0 00000000
1 00000070 0011f863 0 0 0 00000000 00000000 1 00000080
2 00000074 00208533 0 0 0 00000000 00000000 0 00000000
1 00000078 00208863 0 0 0 00000000 00000000 0 00000000
1 0000007c 0030d863 0 0 0 00000000 00000000 1 0000008c
2 00000080 00208533 0 0 0 00000000 00000000 0 00000000
1 00000084 0030e863 0 0 0 00000000 00000000 1 00000094
2 00000088 00208533 0 0 0 00000000 00000000 0 00000000
1 0000008c 0030c863 0 0 0 00000000 00000000 0 00000000
1 00000090 0030f863 0 0 0 00000000 00000000 0 00000000
1 00000094 020000ef 01 1 0 00000098 00000000 1 000000b4
2 00000098 00208533 0 0 0 00000000 00000000 0 00000000
1 0000009c 003202e7 05 1 0 000000a0 00000000 1 00000102
2 000000a0 00208533 0 0 0 00000000 00000000 0 00000000
2 000000a4 0000000f 0 0 0 00000000 00000000 0 00000000
